// ==== verilog/aluOpsPkg.sv ====
package aluOpsPkg;

	//////////////////////////////////////////////////
	// Lane data width
	//////////////////////////////////////////////////

	localparam int dataWidth = 16;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	// 13 to 15 have no operation behind them
	typedef enum logic [3:0]
	{
		addOp  = 4'd0,
		subOp  = 4'd1,
		cmpOp  = 4'd2,
		cmprOp = 4'd3,
		andOp  = 4'd4,
		orOp   = 4'd5,
		xorOp  = 4'd6,
		notOp  = 4'd7,
		lshOp  = 4'd8,
		rshOp  = 4'd9,
		arshOp = 4'd10,
		mulOp  = 4'd11,
		fmulOp = 4'd12
	} aluOpcode;

	//////////////////////////////////////////////////
	// Lane outputs
	//////////////////////////////////////////////////

	typedef struct packed
	{
		logic low;
		logic negative;
		logic zero;
	} laneFlags;

	// d only carries the low half of a full multiply
	typedef struct packed
	{
		logic [dataWidth-1:0] c;
		logic [dataWidth-1:0] d;
		laneFlags flags;
	} laneResult;

endpackage

// ==== verilog/vectorPkg.sv ====
package vectorPkg;

	//////////////////////////////////////////////////
	// Vector shape
	//////////////////////////////////////////////////

	localparam int laneCount = 4;
	localparam int tagWidth = 4;

	typedef logic [aluOpsPkg::dataWidth-1:0] laneWord;

	//////////////////////////////////////////////////
	// B operand, read as a vector or as one scalar
	//////////////////////////////////////////////////

	typedef union packed
	{
		laneWord [laneCount-1:0] vector;
		struct packed
		{
			logic [(laneCount-1)*aluOpsPkg::dataWidth-1:0] pad;
			laneWord value;
		} scalar;
	} operandWord;

	//////////////////////////////////////////////////
	// Request, per-lane operation and response
	//////////////////////////////////////////////////

	typedef struct packed
	{
		aluOpsPkg::aluOpcode opcode;
		logic scalarB;
		logic [tagWidth-1:0] tag;
		laneWord [laneCount-1:0] a;
		operandWord b;
	} vectorRequest;

	// What a single lane sees after the B decode
	typedef struct packed
	{
		aluOpsPkg::aluOpcode opcode;
		laneWord a;
		laneWord b;
	} laneOp;

	typedef struct packed
	{
		logic [tagWidth-1:0] tag;
		laneWord [laneCount-1:0] c;
		laneWord [laneCount-1:0] d;
		aluOpsPkg::laneFlags [laneCount-1:0] flags;
		logic allZero;
		logic anyNegative;
	} vectorResponse;

endpackage

// ==== verilog/issueStage.sv ====
`timescale 1ns/1ps

module issueStage
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input vectorPkg::vectorRequest request,
	output logic issueValid,
	output logic [vectorPkg::tagWidth-1:0] issueTag,
	output vectorPkg::laneOp [vectorPkg::laneCount-1:0] laneOps
);

	import vectorPkg::*;

	laneOp [laneCount-1:0] nextOps;

	//////////////////////////////////////////////////
	// B operand decode
	//////////////////////////////////////////////////

	// Scalar mode broadcasts the low word to every lane
	always_comb
	begin
		for (int lane = 0; lane < laneCount; lane++)
		begin
			nextOps[lane].opcode = request.opcode;
			nextOps[lane].a = request.a[lane];
			if (request.scalarB)
			begin
				nextOps[lane].b = request.b.scalar.value;
			end
			else
			begin
				nextOps[lane].b = request.b.vector[lane];
			end
		end
	end

	//////////////////////////////////////////////////
	// Issue register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issueValid <= 1'b0;
		end
		else
		begin
			issueValid <= inValid;
		end

		if (inValid)
		begin
			issueTag <= request.tag;
			laneOps <= nextOps;
		end
	end

endmodule

// ==== verilog/aluLane.sv ====
`timescale 1ns/1ps

module aluLane
(
	input logic clk,
	input logic reset,
	input logic issueValid,
	input vectorPkg::laneOp op,
	output logic laneValid,
	output aluOpsPkg::laneResult result
);

	import aluOpsPkg::*;
	import vectorPkg::*;

	laneWord a;
	laneWord b;
	logic [2*dataWidth-1:0] product;
	logic signedLess;
	logic signedGreater;
	logic unsignedLess;
	logic unsignedGreater;
	logic operandsEqual;
	laneResult next;

	assign a = op.a;
	assign b = op.b;

	// Full unsigned product, shared by mulOp and fmulOp
	assign product = a * b;

	// Compare terms used by the flag rules
	assign signedLess = $signed(a) < $signed(b);
	assign signedGreater = $signed(b) < $signed(a);
	assign unsignedLess = a < b;
	assign unsignedGreater = b < a;
	assign operandsEqual = (a == b);

	//////////////////////////////////////////////////
	// Operation decode
	//////////////////////////////////////////////////

	always_comb
	begin
		next = '0;
		case (op.opcode)
			addOp:
			begin
				next.c = a + b;
				next.flags.low = signedLess;
				next.flags.negative = next.c[15];
				next.flags.zero = (next.c == '0);
			end
			subOp:
			begin
				next.c = a - b;
				next.flags.low = signedLess;
				next.flags.negative = next.c[15];
				next.flags.zero = operandsEqual;
			end
			// Compares leave c at zero and only set flags
			cmpOp:
			begin
				next.flags.low = unsignedLess;
				next.flags.negative = signedLess;
				next.flags.zero = operandsEqual;
			end
			cmprOp:
			begin
				next.flags.low = unsignedGreater;
				next.flags.negative = signedGreater;
				next.flags.zero = operandsEqual;
			end
			andOp:
			begin
				next.c = a & b;
				next.flags.low = unsignedLess;
				next.flags.negative = next.c[15];
				next.flags.zero = (next.c == '0);
			end
			orOp:
			begin
				next.c = a | b;
				next.flags.low = unsignedLess;
				next.flags.negative = next.c[15];
				next.flags.zero = (next.c == '0);
			end
			xorOp:
			begin
				next.c = a ^ b;
				next.flags.low = unsignedLess;
				next.flags.negative = next.c[15];
				next.flags.zero = (next.c == '0);
			end
			notOp:
			begin
				next.c = ~a;
				next.flags.negative = next.c[15];
				next.flags.zero = (next.c == '0);
			end
			// Shifts move b, amount from the low nibble of a
			lshOp:
			begin
				next.c = b << a[3:0];
				next.flags.zero = (next.c == '0);
			end
			rshOp:
			begin
				next.c = b >> a[3:0];
				next.flags.zero = (next.c == '0);
			end
			arshOp:
			begin
				next.c = $signed(b) >>> a[3:0];
				next.flags.zero = (next.c == '0);
			end
			mulOp:
			begin
				next.c = product[2*dataWidth-1:dataWidth];
				next.d = product[dataWidth-1:0];
				next.flags.zero = (next.c == '0);
			end
			// Fixed point multiply, Q2.14 style
			fmulOp:
			begin
				next.c = product[29:14];
				next.flags.zero = (next.c == '0);
			end
			default:
			begin
				next = '0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Lane output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			laneValid <= 1'b0;
		end
		else
		begin
			laneValid <= issueValid;
		end

		if (issueValid)
		begin
			result <= next;
		end
	end

endmodule

// ==== verilog/resultCollector.sv ====
`timescale 1ns/1ps

module resultCollector
(
	input logic clk,
	input logic reset,
	input logic [vectorPkg::laneCount-1:0] laneValid,
	input aluOpsPkg::laneResult [vectorPkg::laneCount-1:0] laneResults,
	input logic [vectorPkg::tagWidth-1:0] issueTag,
	input logic issueValid,
	output logic outValid,
	output vectorPkg::vectorResponse response
);

	import vectorPkg::*;

	logic [tagWidth-1:0] laneTag;
	vectorResponse next;

	// Tag follows the lanes one stage behind issue
	always_ff @(posedge clk)
	begin
		if (issueValid)
		begin
			laneTag <= issueTag;
		end
	end

	//////////////////////////////////////////////////
	// Response assembly
	//////////////////////////////////////////////////

	always_comb
	begin
		next.tag = laneTag;
		next.allZero = 1'b1;
		next.anyNegative = 1'b0;
		for (int lane = 0; lane < laneCount; lane++)
		begin
			next.c[lane] = laneResults[lane].c;
			next.d[lane] = laneResults[lane].d;
			next.flags[lane] = laneResults[lane].flags;
			next.allZero = next.allZero & laneResults[lane].flags.zero;
			next.anyNegative = next.anyNegative | laneResults[lane].flags.negative;
		end
	end

	// Lanes run in lockstep, lane 0 stands for all
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= laneValid[0];
		end

		if (laneValid[0])
		begin
			response <= next;
		end
	end

endmodule

// ==== verilog/vectorAlu.sv ====
`timescale 1ns/1ps

module vectorAlu
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input vectorPkg::vectorRequest request,
	output logic outValid,
	output vectorPkg::vectorResponse response
);

	import aluOpsPkg::*;
	import vectorPkg::*;

	logic issueValid;
	logic [tagWidth-1:0] issueTag;
	laneOp [laneCount-1:0] laneOps;
	logic [laneCount-1:0] laneValid;
	laneResult [laneCount-1:0] laneResults;

	issueStage issue
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.request(request),
		.issueValid(issueValid),
		.issueTag(issueTag),
		.laneOps(laneOps)
	);

	//////////////////////////////////////////////////
	// ALU lanes
	//////////////////////////////////////////////////

	for (genvar lane = 0; lane < laneCount; lane++)
	begin : lanes
		aluLane alu
		(
			.clk(clk),
			.reset(reset),
			.issueValid(issueValid),
			.op(laneOps[lane]),
			.laneValid(laneValid[lane]),
			.result(laneResults[lane])
		);
	end

	resultCollector collector
	(
		.clk(clk),
		.reset(reset),
		.laneValid(laneValid),
		.laneResults(laneResults),
		.issueTag(issueTag),
		.issueValid(issueValid),
		.outValid(outValid),
		.response(response)
	);

endmodule

// ==== test/vectorAluChecker.sv ====
`timescale 1ns/1ps

module vectorAluChecker
(
	input logic clk,
	input logic reset,
	input logic expectValid,
	input vectorPkg::vectorResponse expected,
	input logic outValid,
	input vectorPkg::vectorResponse response,
	input logic endOfTest,
	output int pending,
	output int mismatchCount,
	output int otherErrors
);

	import vectorPkg::*;

	// Cycles from the request edge to the edge where outValid is first seen high
	localparam int responseLatency = 3;

	vectorResponse expectQueue [$];
	int issueQueue [$];
	int cycleCount;
	logic endChecked;

	task automatic compareField(input string name, input logic [15:0] want,
		input logic [15:0] got);
		if (got !== want)
		begin
			$display("mismatch at %0d ns: %s expected %h, got %h", $time, name, want, got);
			mismatchCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// Response comparison
	//////////////////////////////////////////////////

	task automatic checkResponse();
		vectorResponse want;
		int issued;
		if (expectQueue.size() == 0)
		begin
			$display("Response with tag %h came out at %0d ns with no request outstanding",
				response.tag, $time);
			otherErrors++;
		end
		else
		begin
			want = expectQueue.pop_front();
			issued = issueQueue.pop_front();
			if (cycleCount - issued != responseLatency)
			begin
				$display("Response with tag %h came out %0d cycles after its request, not %0d",
					response.tag, cycleCount - issued, responseLatency);
				otherErrors++;
			end
			compareField("tag", {12'b0, want.tag}, {12'b0, response.tag});
			for (int lane = 0; lane < laneCount; lane++)
			begin
				compareField($sformatf("c[%0d]", lane), want.c[lane], response.c[lane]);
				compareField($sformatf("d[%0d]", lane), want.d[lane], response.d[lane]);
				compareField($sformatf("flags[%0d]", lane), {13'b0, want.flags[lane]},
					{13'b0, response.flags[lane]});
			end
			compareField("allZero", {15'b0, want.allZero}, {15'b0, response.allZero});
			compareField("anyNegative", {15'b0, want.anyNegative},
				{15'b0, response.anyNegative});
		end
	endtask

	// Sampled on the rising edge, before the DUT registers update
	always @(posedge clk)
	begin
		if (reset)
		begin
			cycleCount = 0;
			mismatchCount = 0;
			otherErrors = 0;
			endChecked = 1'b0;
			expectQueue.delete();
			issueQueue.delete();
		end
		else
		begin
			if (expectValid)
			begin
				expectQueue.push_back(expected);
				issueQueue.push_back(cycleCount);
			end
			if (outValid)
				checkResponse();
			if (endOfTest && !endChecked)
			begin
				endChecked = 1'b1;
				if (expectQueue.size() != 0)
				begin
					$display("%0d expected responses never came out of the DUT",
						expectQueue.size());
					otherErrors += expectQueue.size();
				end
			end
			cycleCount++;
		end
		pending = expectQueue.size();
	end

endmodule

// ==== test/vectorAluTb.sv ====
`timescale 1ns/1ps

module vectorAluTb;

	import aluOpsPkg::*;
	import vectorPkg::*;

	localparam int clockPeriod = 100;
	localparam int resetCycles = 3;
	localparam int tableRows = 20;
	localparam int randomCount = 200;
	localparam int gapEvery = 8;
	localparam int drainCycles = 10;
	// Every cycle the run needs, with some slack on top
	localparam int watchdogTime = (tableRows + randomCount + randomCount / gapEvery
		+ resetCycles + drainCycles + 20) * clockPeriod;

	typedef struct packed
	{
		aluOpcode opcode;
		logic scalarB;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		logic [63:0] d;
		logic [11:0] flags;
	} directedRow;

	logic clk;
	logic reset;
	logic inValid;
	vectorRequest request;
	logic outValid;
	vectorResponse response;
	logic expectValid;
	vectorResponse expected;
	logic endOfTest;
	int pending;
	int mismatchCount;
	int otherErrors;
	logic [31:0] lcgState;

	//////////////////////////////////////////////////
	// Directed rows
	//////////////////////////////////////////////////

	// Lane 3 is the leftmost word of each 64-bit value
	// Flags per lane are low, negative, zero
	directedRow directedRows [tableRows] = '{
		'{addOp, 1'b0, 64'h7FFF_8000_FFFF_0001, 64'h0001_FFFF_0001_0002,
			64'h8000_7FFF_0000_0003, 64'h0, 12'b010_100_101_100},
		'{subOp, 1'b0, 64'h8000_7FFF_1234_0000, 64'h0001_FFFF_1234_0001,
			64'h7FFF_8000_0000_FFFF, 64'h0, 12'b100_010_001_110},
		'{cmpOp, 1'b0, 64'h8000_0001_7FFF_5555, 64'h7FFF_8000_7FFF_0005,
			64'h0, 64'h0, 12'b010_100_001_000},
		'{cmprOp, 1'b0, 64'h8000_0001_7FFF_5555, 64'h7FFF_8000_7FFF_0005,
			64'h0, 64'h0, 12'b100_010_001_110},
		'{andOp, 1'b0, 64'hF0F0_FFFF_8001_0000, 64'h0F0F_8000_FFFF_1234,
			64'h0000_8000_8001_0000, 64'h0, 12'b001_010_110_101},
		'{orOp, 1'b0, 64'hF0F0_0000_1200_0001, 64'h0F0F_0000_0034_8000,
			64'hFFFF_0000_1234_8001, 64'h0, 12'b010_001_000_110},
		'{xorOp, 1'b0, 64'hAAAA_1234_FFFF_0000, 64'h5555_1234_0001_8000,
			64'hFFFF_0000_FFFE_8000, 64'h0, 12'b010_001_010_110},
		'{notOp, 1'b0, 64'h0000_FFFF_8000_1234, 64'h1111_2222_3333_4444,
			64'hFFFF_0000_7FFF_EDCB, 64'h0, 12'b010_001_000_010},
		'{lshOp, 1'b1, 64'h0000_FFF1_0104_000F, 64'hDEAD_BEEF_0BAD_8421,
			64'h8421_0842_4210_8000, 64'h0, 12'b000_000_000_000},
		'{rshOp, 1'b1, 64'h0010_0003_FF08_000F, 64'hDEAD_BEEF_0BAD_8421,
			64'h8421_1084_0084_0001, 64'h0, 12'b000_000_000_000},
		'{arshOp, 1'b1, 64'h0000_0001_0007_000F, 64'hDEAD_BEEF_0BAD_8421,
			64'h8421_C210_FF08_FFFF, 64'h0, 12'b000_000_000_000},
		'{arshOp, 1'b0, 64'h0002_0005_000C_000E, 64'hF000_7FFF_8000_0001,
			64'hFC00_03FF_FFF8_0000, 64'h0, 12'b000_000_000_001},
		'{mulOp, 1'b0, 64'hFFFF_1234_0000_0100, 64'hFFFF_0010_5678_0100,
			64'hFFFE_0001_0000_0001, 64'h0001_2340_0000_0000, 12'b000_000_001_000},
		'{mulOp, 1'b0, 64'h0003_00FF_8000_0002, 64'h0005_0101_0002_7FFF,
			64'h0000_0000_0001_0000, 64'h000F_FFFF_0000_FFFE, 12'b001_001_000_001},
		'{fmulOp, 1'b0, 64'h4000_2000_FFFF_0001, 64'h4000_6000_FFFF_0001,
			64'h4000_3000_FFF8_0000, 64'h0, 12'b000_000_000_001},
		'{addOp, 1'b1, 64'h0001_7FFF_FFFF_8000, 64'h1111_2222_3333_FFFF,
			64'h0000_7FFE_FFFE_7FFF, 64'h0, 12'b001_000_010_100},
		'{cmpOp, 1'b1, 64'h0005_0004_0003_8000, 64'hFFFF_FFFF_FFFF_0004,
			64'h0, 64'h0, 12'b000_001_110_010},
		'{subOp, 1'b1, 64'h1234_1234_1234_1234, 64'hABCD_ABCD_ABCD_1234,
			64'h0, 64'h0, 12'b001_001_001_001},
		'{aluOpcode'(4'd13), 1'b0, 64'hFFFF_8000_1234_0001, 64'h0001_FFFF_1234_8000,
			64'h0, 64'h0, 12'b000_000_000_000},
		'{aluOpcode'(4'd15), 1'b1, 64'h7FFF_0000_FFFF_5A5A, 64'h8000_8000_8000_8000,
			64'h0, 64'h0, 12'b000_000_000_000}
	};

	vectorAlu UUT
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.request(request),
		.outValid(outValid),
		.response(response)
	);

	vectorAluChecker responseCheck
	(
		.clk(clk),
		.reset(reset),
		.expectValid(expectValid),
		.expected(expected),
		.outValid(outValid),
		.response(response),
		.endOfTest(endOfTest),
		.pending(pending),
		.mismatchCount(mismatchCount),
		.otherErrors(otherErrors)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic laneResult modelLane(input aluOpcode opcode, input laneWord a,
		input laneWord b);
		laneResult r;
		logic [31:0] product;
		logic [31:0] extended;
		logic signedLess;
		logic signedGreater;
		r = '0;
		product = {16'h0, a} * {16'h0, b};
		extended = {{16{b[15]}}, b} >> a[3:0];
		signedLess = $signed(a) < $signed(b);
		signedGreater = $signed(a) > $signed(b);
		case (opcode)
			addOp: r.c = a + b;
			subOp: r.c = a - b;
			andOp: r.c = a & b;
			orOp: r.c = a | b;
			xorOp: r.c = a ^ b;
			notOp: r.c = ~a;
			lshOp: r.c = b << a[3:0];
			rshOp: r.c = b >> a[3:0];
			arshOp: r.c = extended[15:0];
			mulOp: r.c = product[31:16];
			fmulOp: r.c = product[29:14];
			default: r.c = 16'h0;
		endcase
		if (opcode == mulOp)
			r.d = product[15:0];
		// Undefined opcodes keep every flag at 0
		if (opcode inside {subOp, cmpOp, cmprOp})
			r.flags.zero = (a == b);
		else if (opcode <= fmulOp)
			r.flags.zero = (r.c == 16'h0);
		if (opcode inside {addOp, subOp})
			r.flags.low = signedLess;
		else if (opcode inside {cmpOp, andOp, orOp, xorOp})
			r.flags.low = (a < b);
		else if (opcode == cmprOp)
			r.flags.low = (b < a);
		if (opcode inside {addOp, subOp, andOp, orOp, xorOp, notOp})
			r.flags.negative = r.c[15];
		else if (opcode == cmpOp)
			r.flags.negative = signedLess;
		else if (opcode == cmprOp)
			r.flags.negative = signedGreater;
		return r;
	endfunction

	function automatic vectorResponse assembleResponse(input logic [3:0] tag,
		input laneWord [laneCount-1:0] c, input laneWord [laneCount-1:0] d,
		input laneFlags [laneCount-1:0] flags);
		vectorResponse resp;
		resp.tag = tag;
		resp.c = c;
		resp.d = d;
		resp.flags = flags;
		resp.allZero = 1'b1;
		resp.anyNegative = 1'b0;
		for (int lane = 0; lane < laneCount; lane++)
		begin
			resp.allZero = resp.allZero & flags[lane].zero;
			resp.anyNegative = resp.anyNegative | flags[lane].negative;
		end
		return resp;
	endfunction

	function automatic vectorResponse modelResponse(input vectorRequest req);
		logic [63:0] bWord;
		laneWord [laneCount-1:0] c;
		laneWord [laneCount-1:0] d;
		laneFlags [laneCount-1:0] flags;
		laneResult r;
		bWord = req.b;
		for (int lane = 0; lane < laneCount; lane++)
		begin
			// Scalar mode uses the lowest word for every lane
			r = modelLane(req.opcode, req.a[lane],
				req.scalarB ? bWord[15:0] : bWord[16*lane +: 16]);
			c[lane] = r.c;
			d[lane] = r.d;
			flags[lane] = r.flags;
		end
		return assembleResponse(req.tag, c, d, flags);
	endfunction

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic sendRequest(input vectorRequest req, input vectorResponse exp);
		@(posedge clk);
		inValid <= 1'b1;
		request <= req;
		expectValid <= 1'b1;
		expected <= exp;
	endtask

	task automatic idleCycle();
		@(posedge clk);
		inValid <= 1'b0;
		expectValid <= 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(watchdogTime);
		$display("Watchdog expired at %0d ns before the run finished", $time);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		vectorRequest req;
		directedRow row;
		logic [31:0] word;
		logic [3:0] tag;
		reset = 1'b1;
		inValid = 1'b0;
		request = '0;
		expectValid = 1'b0;
		expected = '0;
		endOfTest = 1'b0;
		lcgState = 32'h286d_dfe8;
		tag = 4'd0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		// Directed rows go back to back
		for (int i = 0; i < tableRows; i++)
		begin
			row = directedRows[i];
			req.opcode = row.opcode;
			req.scalarB = row.scalarB;
			req.tag = tag;
			req.a = row.a;
			req.b = row.b;
			sendRequest(req, assembleResponse(tag, row.c, row.d, row.flags));
			tag = tag + 4'd1;
		end

		// Random rows with a dropped inValid every few requests
		for (int i = 0; i < randomCount; i++)
		begin
			word = nextRandom();
			req.opcode = aluOpcode'(word[31:28]);
			req.scalarB = word[27];
			req.tag = tag;
			req.a = {nextRandom(), nextRandom()};
			req.b = {nextRandom(), nextRandom()};
			sendRequest(req, modelResponse(req));
			tag = tag + 4'd1;
			if (i % gapEvery == gapEvery - 1)
				idleCycle();
		end
		idleCycle();

		@(negedge clk);
		for (int i = 0; i < drainCycles && pending != 0; i++)
			@(negedge clk);
		@(posedge clk);
		endOfTest <= 1'b1;
		@(posedge clk);
		@(negedge clk);

		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/aluOpsPkg.sv
verilog/vectorPkg.sv
verilog/issueStage.sv
verilog/aluLane.sv
verilog/resultCollector.sv
verilog/vectorAlu.sv
test/vectorAluChecker.sv
test/vectorAluTb.sv

// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --timing -j 0 --top-module vectorAluTb -Mdir obj_dir -f tb.f
	@out="$$(./obj_dir/VvectorAluTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
